// File: rtl/fis_tx_config.svh
`ifndef FIS_TX_CONFIG_SVH
`define FIS_TX_CONFIG_SVH

// register memory, port registers in the low half, command list in the upper half
`define FIS_TX_REG_AW     10
`define FIS_TX_CLB_OFFS   'h200   // dword address of the command header

// read latencies, cycles from the read strobe to valid data
`define FIS_TX_REG_LAT    2
`define FIS_TX_CT_LAT     2

// data FIS, h2d direction
`define FIS_TX_DATA_FIS   'h46    // header dword, type 0x46
`define FIS_TX_MAX_DX_DW  2048    // max dwords in one data FIS (8KB)

`endif

// File: rtl/fis_tx_pkg.sv
package fis_tx_pkg;

    typedef logic [31:0] dword_t;   // one dword toward the link
    typedef logic [11:0] dx_cnt_t;  // data FIS dword count, 0..2048
    typedef logic [4:0]  cfl_t;     // command FIS length in dwords

    // tag that travels with every word to the send FIFO
    // bit 0 marks the first dword of a FIS, bit 1 the last one
    typedef enum logic [1:0] {
        TT_DATA      = 2'd0,
        TT_HEAD      = 2'd1,
        TT_LAST      = 2'd2,
        TT_HEAD_LAST = 2'd3
    } todev_type_t;

endpackage

// File: rtl/chead_fetch.sv
`timescale 1ns/1ps
`include "fis_tx_config.svh"

module chead_fetch (
    input  logic                         mclk,
    input  logic                         hba_rst,
    input  logic                         fetch_cmd,  // strobe, read command header
    input  fis_tx_pkg::dword_t           reg_rdata,  // register memory read data
    output logic [`FIS_TX_REG_AW-1:0]    reg_addr,
    output logic                         reg_re,
    output logic [15:0]                  ch_prdtl,   // PRD table length, entries
    output logic                         ch_w,       // write, memory -> device
    output fis_tx_pkg::cfl_t             ch_cfl,     // command FIS length
    output logic                         hdr_done    // fields load on this cycle
);
    import fis_tx_pkg::*;

    localparam int LAT = `FIS_TX_REG_LAT;
    localparam logic [`FIS_TX_REG_AW-1:0] CLB_ADDR = `FIS_TX_CLB_OFFS;

    logic           hdr_bsy;    // from accepted fetch_cmd until header captured
    logic [LAT-1:0] re_pipe;    // read strobe delayed to the data return
    logic           cap_stb;    // reg_rdata holds the header dword
    logic           start_w;

    assign start_w  = fetch_cmd && !hdr_bsy;     // second strobe while busy is dropped
    assign cap_stb  = re_pipe[LAT-1] && hdr_bsy;
    assign hdr_done = cap_stb;

    // one read, one cycle after the strobe
    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            reg_re <= 1'b0;
        end else begin
            reg_re <= start_w;
        end
    end

    always_ff @(posedge mclk) begin
        if (start_w) begin
            reg_addr <= CLB_ADDR;   // only dword 0 of the header is needed
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            re_pipe <= '0;
        end else begin
            re_pipe <= {re_pipe[LAT-2:0], reg_re};
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            hdr_bsy <= 1'b0;
        end else if (start_w) begin
            hdr_bsy <= 1'b1;
        end else if (cap_stb) begin
            hdr_bsy <= 1'b0;
        end
    end

    // header dword 0: prdtl in [31:16], w in bit 6, cfl in [4:0]
    always_ff @(posedge mclk) begin
        if (cap_stb) begin
            ch_prdtl <= reg_rdata[31:16];
            ch_w     <= reg_rdata[6];
            ch_cfl   <= cfl_t'(reg_rdata[4:0]);
        end
    end

endmodule

// File: rtl/cfis_sender.sv
`timescale 1ns/1ps
`include "fis_tx_config.svh"

module cfis_sender (
    input  logic                     mclk,
    input  logic                     hba_rst,
    input  logic                     cfis_xmit,   // strobe, send command FIS
    input  fis_tx_pkg::cfl_t         ch_cfl,      // length from the header
    input  fis_tx_pkg::dword_t       ct_data,     // command table read data
    input  logic                     todev_ready, // FIFO has room
    output logic [4:0]               ct_addr,     // dword address in the table
    output logic                     ct_re,
    output logic                     cf_wr,       // write to the output register
    output fis_tx_pkg::dword_t       cf_data,
    output fis_tx_pkg::todev_type_t  cf_type,
    output logic                     cf_done      // with the last write
);
    import fis_tx_pkg::*;

    localparam int LAT = `FIS_TX_CT_LAT;

    cfl_t           req_left;   // dwords still to be requested
    cfl_t           rcv_left;   // dwords still to arrive
    logic [LAT-1:0] rd_pipe;    // one bit per read in flight
    logic           ct_stb;     // ct_data valid
    logic           first_dw;   // next arriving dword opens the FIS
    logic           last_dw;

    assign ct_re   = (req_left != '0) && todev_ready;   // stall while FIFO is full
    assign ct_stb  = rd_pipe[LAT-1];
    assign last_dw = (rcv_left == cfl_t'(1));

    assign cf_wr   = ct_stb;        // written as soon as it arrives
    assign cf_data = ct_data;
    assign cf_type = todev_type_t'({last_dw, first_dw});   // head_last for 1 dword
    assign cf_done = ct_stb && last_dw;

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            req_left <= '0;
        end else if (cfis_xmit) begin
            req_left <= ch_cfl;
        end else if (ct_re) begin
            req_left <= req_left - cfl_t'(1);
        end
    end

    always_ff @(posedge mclk) begin
        if (cfis_xmit) begin
            ct_addr <= '0;                      // CFIS area starts at dword 0
        end else if (ct_re) begin
            ct_addr <= ct_addr + 5'd1;
        end
    end

    // several reads may overlap, the pipe keeps them in order
    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            rd_pipe <= '0;
        end else begin
            rd_pipe <= {rd_pipe[LAT-2:0], ct_re};
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            rcv_left <= '0;
            first_dw <= 1'b0;
        end else if (cfis_xmit) begin
            rcv_left <= ch_cfl;
            first_dw <= 1'b1;
        end else if (ct_stb) begin
            rcv_left <= rcv_left - cfl_t'(1);
            first_dw <= 1'b0;
        end
    end

endmodule

// File: rtl/dx_sender.sv
`timescale 1ns/1ps
`include "fis_tx_config.svh"

module dx_sender (
    input  logic                     mclk,
    input  logic                     hba_rst,
    input  logic                     dx_transmit,  // strobe, send data FIS
    input  logic [29:0]              xfer_cntr,    // remaining transfer, dwords
    input  fis_tx_pkg::dword_t       dma_out,
    input  logic                     dma_dav,      // DMA has a dword
    input  logic                     todev_ready,
    input  logic [1:0]               dx_err,       // link error seen, stops forwarding
    output logic                     dma_re,
    output logic                     dx_wr,
    output fis_tx_pkg::dword_t       dx_data,
    output fis_tx_pkg::todev_type_t  dx_type,
    output fis_tx_pkg::dx_cnt_t      dwords_sent,
    output logic                     dx_done
);
    import fis_tx_pkg::*;

    localparam dx_cnt_t MAX_DW   = dx_cnt_t'(`FIS_TX_MAX_DX_DW);
    localparam dword_t  DATA_FIS = dword_t'(`FIS_TX_DATA_FIS);

    dx_cnt_t budget;    // dwords left in this FIS
    logic    hdr_pend;  // header dword not yet written
    logic    dma_en;    // forwarding DMA dwords
    logic    dx_act;    // command running, done not yet given
    logic    hdr_wr;
    logic    empty_w;   // nothing to forward after the header
    logic    last_w;

    assign hdr_wr  = hdr_pend && todev_ready;
    assign empty_w = (budget == '0);
    assign last_w  = (budget == dx_cnt_t'(1));
    assign dma_re  = dma_en && dma_dav && todev_ready;

    assign dx_wr   = hdr_wr || dma_re;
    assign dx_data = hdr_pend ? DATA_FIS : dma_out;
    always_comb begin
        if (hdr_pend) begin
            dx_type = empty_w ? TT_HEAD_LAST : TT_HEAD;
        end else begin
            dx_type = last_w ? TT_LAST : TT_DATA;
        end
    end

    // last dword, empty FIS after header, or a link error
    assign dx_done = dx_act && ((dma_re && last_w) || (hdr_wr && empty_w) || (dx_err != 2'b00));

    always_ff @(posedge mclk) begin
        if (dx_transmit) begin
            budget <= (xfer_cntr > 30'(MAX_DW)) ? MAX_DW : xfer_cntr[11:0];   // clamp to 2048
        end else if (dma_re) begin
            budget <= budget - dx_cnt_t'(1);
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst || dx_transmit) begin
            dwords_sent <= '0;
        end else if (dma_re) begin
            dwords_sent <= dwords_sent + dx_cnt_t'(1);
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            hdr_pend <= 1'b0;
            dma_en   <= 1'b0;
            dx_act   <= 1'b0;
        end else begin
            if (dx_transmit) begin
                hdr_pend <= 1'b1;
            end else if (hdr_wr || dx_err != 2'b00) begin
                hdr_pend <= 1'b0;
            end
            if (dx_done) begin
                dma_en <= 1'b0;
            end else if (hdr_wr) begin
                dma_en <= !empty_w;             // data follows from the next cycle
            end
            if (dx_transmit) begin
                dx_act <= 1'b1;
            end else if (dx_done) begin
                dx_act <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/todev_stage.sv
`timescale 1ns/1ps

module todev_stage (
    input  logic                     mclk,
    input  logic                     hba_rst,
    input  logic                     cf_wr,
    input  fis_tx_pkg::dword_t       cf_data,
    input  fis_tx_pkg::todev_type_t  cf_type,
    input  logic                     dx_wr,
    input  fis_tx_pkg::dword_t       dx_data,
    input  fis_tx_pkg::todev_type_t  dx_type,
    input  logic                     todev_ready,
    input  logic                     syncesc_recv,  // pulse from link
    input  logic                     xmit_err,      // pulse from link
    input  logic                     fetch_cmd,
    input  logic                     cfis_xmit,
    input  logic                     dx_transmit,
    output fis_tx_pkg::dword_t       todev_data,
    output fis_tx_pkg::todev_type_t  todev_type,
    output logic                     todev_valid,   // output register full
    output logic [1:0]               dx_err         // bit 0 sync escape, bit 1 xmit error
);
    logic wr_w;
    logic any_cmd;

    assign wr_w    = cf_wr || dx_wr;   // senders never write together
    assign any_cmd = fetch_cmd || cfis_xmit || dx_transmit;

    always_ff @(posedge mclk) begin
        if (wr_w) begin
            todev_data <= dx_wr ? dx_data : cf_data;
            todev_type <= dx_wr ? dx_type : cf_type;
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            todev_valid <= 1'b0;
        end else if (wr_w) begin
            todev_valid <= 1'b1;
        end else if (todev_ready) begin
            todev_valid <= 1'b0;       // taken by the FIFO
        end
    end

    // sticky until the next command
    always_ff @(posedge mclk) begin
        if (hba_rst || any_cmd) begin
            dx_err <= 2'b00;
        end else begin
            if (syncesc_recv) dx_err[0] <= 1'b1;
            if (xmit_err)     dx_err[1] <= 1'b1;
        end
    end

endmodule

// File: rtl/fis_transmit.sv
`timescale 1ns/1ps
`include "fis_tx_config.svh"

module fis_transmit (
    input  logic                         mclk,
    input  logic                         hba_rst,
    input  logic                         fetch_cmd,     // command strobes
    input  logic                         cfis_xmit,
    input  logic                         dx_transmit,
    output logic                         done,
    output logic                         busy,
    input  logic                         syncesc_recv,
    input  logic                         xmit_err,
    output logic [1:0]                   dx_err,
    output logic [15:0]                  ch_prdtl,
    output logic                         ch_w,
    output fis_tx_pkg::cfl_t             ch_cfl,
    output fis_tx_pkg::dx_cnt_t          dwords_sent,
    output logic [`FIS_TX_REG_AW-1:0]    reg_addr,      // register memory port
    output logic                         reg_re,
    input  fis_tx_pkg::dword_t           reg_rdata,
    input  logic [29:0]                  xfer_cntr,
    output logic [4:0]                   ct_addr,       // command table port
    output logic                         ct_re,
    input  fis_tx_pkg::dword_t           ct_data,
    input  fis_tx_pkg::dword_t           dma_out,       // DMA source
    input  logic                         dma_dav,
    output logic                         dma_re,
    output fis_tx_pkg::dword_t           todev_data,    // toward the send FIFO
    output fis_tx_pkg::todev_type_t      todev_type,
    output logic                         todev_valid,
    input  logic                         todev_ready
);
    import fis_tx_pkg::*;

    logic        cf_wr, dx_wr;
    dword_t      cf_data, dx_data;
    todev_type_t cf_type, dx_type;
    logic        hdr_done, cf_done, dx_done;
    logic        fin_w;
    logic        any_cmd;

    assign fin_w   = hdr_done || cf_done || dx_done;
    assign any_cmd = fetch_cmd || cfis_xmit || dx_transmit;

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            done <= 1'b0;
            busy <= 1'b0;
        end else begin
            done <= fin_w;
            if (any_cmd) busy <= 1'b1;
            else if (fin_w) busy <= 1'b0;   // low together with done
        end
    end

    chead_fetch i_chead_fetch (
        .mclk, .hba_rst, .fetch_cmd, .reg_rdata, .reg_addr, .reg_re,
        .ch_prdtl, .ch_w, .ch_cfl, .hdr_done
    );

    cfis_sender i_cfis_sender (
        .mclk, .hba_rst, .cfis_xmit, .ch_cfl, .ct_data, .todev_ready,
        .ct_addr, .ct_re, .cf_wr, .cf_data, .cf_type, .cf_done
    );

    dx_sender i_dx_sender (
        .mclk, .hba_rst, .dx_transmit, .xfer_cntr, .dma_out, .dma_dav, .todev_ready,
        .dx_err, .dma_re, .dx_wr, .dx_data, .dx_type, .dwords_sent, .dx_done
    );

    todev_stage i_todev_stage (
        .mclk, .hba_rst, .cf_wr, .cf_data, .cf_type, .dx_wr, .dx_data, .dx_type,
        .todev_ready, .syncesc_recv, .xmit_err, .fetch_cmd, .cfis_xmit, .dx_transmit,
        .todev_data, .todev_type, .todev_valid, .dx_err
    );

endmodule

// File: bench/fis_transmit_tb.sv
`timescale 1ns/1ps
`include "fis_tx_config.svh"

module fis_transmit_tb;
    import fis_tx_pkg::*;

    localparam int NROWS   = 9;
    localparam int K_FETCH = 0;   // header fetch only
    localparam int K_CFIS  = 1;   // header fetch, then command FIS
    localparam int K_DX    = 2;   // data FIS

    // err: 0 none, 1 sync escape, 2 xmit error, pulsed err_at cycles after the strobe
    // exp_words: words at the sink, an upper bound on abort rows
    typedef struct packed {
        int          kind;
        logic [31:0] hdr;
        int          xfer;
        int          err;
        int          err_at;
        logic        rnd;       // random todev_ready
        int          exp_words;
    } row_t;

    string names [NROWS] = '{"hdr_fetch", "cfis_1", "cfis_5", "cfis_16", "dx_short",
                             "dx_clamp", "dx_xmit_err", "dx_syncesc", "dx_after_err"};
    row_t  rows [NROWS] = '{
        '{K_FETCH, 32'hBEEF_0057, 0,    0, 0,  1'b0, 0},
        '{K_CFIS,  32'h0001_0001, 0,    0, 0,  1'b0, 1},
        '{K_CFIS,  32'h0002_0045, 0,    0, 0,  1'b0, 5},
        '{K_CFIS,  32'h0004_0010, 0,    0, 0,  1'b0, 16},
        '{K_DX,    32'h0,         37,   0, 0,  1'b1, 38},
        '{K_DX,    32'h0,         5000, 0, 0,  1'b0, 2049},
        '{K_DX,    32'h0,         300,  2, 40, 1'b0, 41},
        '{K_DX,    32'h0,         300,  1, 25, 1'b1, 26},
        '{K_DX,    32'h0,         3,    0, 0,  1'b0, 4}
    };

    logic        mclk = 1'b0;
    logic        hba_rst = 1'b1;
    logic        fetch_cmd = 1'b0;
    logic        cfis_xmit = 1'b0;
    logic        dx_transmit = 1'b0;
    logic        syncesc_recv = 1'b0;
    logic        xmit_err = 1'b0;
    logic [29:0] xfer_cntr = '0;
    logic        dma_dav = 1'b0;
    logic        todev_ready = 1'b0;
    dword_t      reg_rdata, ct_data, dma_out;

    logic        done, busy, ch_w, reg_re, ct_re, dma_re, todev_valid;
    logic [1:0]  dx_err;
    logic [15:0] ch_prdtl;
    cfl_t        ch_cfl;
    dx_cnt_t     dwords_sent;
    logic [`FIS_TX_REG_AW-1:0] reg_addr;
    logic [4:0]  ct_addr;
    dword_t      todev_data;
    todev_type_t todev_type;

    dword_t      reg_pipe [`FIS_TX_REG_LAT] = '{default: 32'hBAD0_BAD0};  // register read pipe
    dword_t      ct_pipe [`FIS_TX_CT_LAT] = '{default: 32'hBAD0_BAD0};    // table read pipe
    dword_t      hdr_word = '0;                // header the register memory holds
    dword_t      sink_data [$];
    logic [1:0]  sink_type [$];
    int          dma_idx = 0;                  // dwords taken from the DMA source
    int          rd_cnt = 0;
    int          bad_addr = 0;
    integer      seed = 26;
    int          rv;
    logic        rnd_rdy = 1'b0;
    int          cyc = 0;
    int          limit = 0;
    int          n_err = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    string       cur_name = "reset";

    fis_transmit i_fis_transmit (.*);

    initial begin
        forever #10 mclk = ~mclk;
    end

    assign reg_rdata = reg_pipe[`FIS_TX_REG_LAT-1];
    assign ct_data   = ct_pipe[`FIS_TX_CT_LAT-1];
    assign dma_out   = 32'hD000_0000 + dma_idx;   // source holds its running index

    // memory models, data shows up LAT cycles after the read strobe
    always @(posedge mclk) begin
        reg_pipe[0] <= reg_re ? hdr_word : 32'hBAD0_BAD0;
        ct_pipe[0]  <= ct_re ? 32'hC0DE_0000 + 32'(ct_addr) : 32'hBAD0_BAD0;
        for (int k = 1; k < `FIS_TX_REG_LAT; k++) begin
            reg_pipe[k] <= reg_pipe[k-1];
        end
        for (int k = 1; k < `FIS_TX_CT_LAT; k++) begin
            ct_pipe[k] <= ct_pipe[k-1];
        end
    end

    always @(posedge mclk) begin
        rv = $random(seed);
        dma_dav     <= (rv[2:1] != 2'b00);         // about 3 cycles in 4
        todev_ready <= rnd_rdy ? rv[0] : 1'b1;
    end

    // read port checks, DMA consumption and the sink
    always @(posedge mclk) begin
        if (reg_re) begin
            rd_cnt <= rd_cnt + 1;
            if (int'(reg_addr) != `FIS_TX_CLB_OFFS) begin
                bad_addr <= bad_addr + 1;
            end
        end
        if (dma_re) begin
            dma_idx <= dma_idx + 1;                 // one dword per dma_re
        end
        if (todev_valid && todev_ready) begin
            sink_data.push_back(todev_data);
            sink_type.push_back(todev_type);
        end
    end

    always @(posedge mclk) begin
        cyc <= cyc + 1;
        if (cyc >= limit) begin
            $display("timeout in test %s: done never came", cur_name);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("Fail %s %s: expected %0h, actual %0h", cur_name, what, exp, act);
        n_err++;
    endtask

    // bit 0 opens the FIS, bit 1 closes it
    function automatic logic [1:0] tag_of(input int j, input int n);
        return {j == n - 1, j == 0};
    endfunction

    // strobe on an edge, then wait for done, lat counts cycles from strobe to done
    task automatic issue_and_wait(input int kind, input row_t r, output int lat);
        logic exp_busy;
        @(posedge mclk);
        fetch_cmd   <= (kind == K_FETCH);
        cfis_xmit   <= (kind == K_CFIS);
        dx_transmit <= (kind == K_DX);
        hdr_word    <= r.hdr;
        xfer_cntr   <= 30'(r.xfer);
        rnd_rdy     <= r.rnd;
        lat = 0;
        do begin
            @(posedge mclk);
            lat++;
            exp_busy = (lat > 1) && !done;   // up from the cycle after the strobe, down with done
            if (busy != exp_busy) mismatch($sformatf("busy at cycle %0d", lat - 1),
                32'(exp_busy), 32'(busy));
            fetch_cmd    <= 1'b0;
            cfis_xmit    <= 1'b0;
            dx_transmit  <= 1'b0;
            xmit_err     <= (r.err == 2 && lat == r.err_at);
            syncesc_recv <= (r.err == 1 && lat == r.err_at);
        end while (!done);
        lat = lat - 1;
    endtask

    task automatic drain;
        @(posedge mclk);
        rnd_rdy      <= 1'b0;                       // ready held high, last word leaves
        xmit_err     <= 1'b0;
        syncesc_recv <= 1'b0;
        repeat (6) @(posedge mclk);
        @(negedge mclk);
    endtask

    task automatic run_row(input int i);
        row_t r;
        int   err0, lat, first, idx0, idx_done, rd0, bad0, got, nd, exp_sent;
        logic [31:0] exp_d;
        r = rows[i];
        cur_name = names[i];
        err0 = n_err;
        if (r.kind != K_DX) begin
            @(negedge mclk);
            rd0  = rd_cnt;
            bad0 = bad_addr;
            issue_and_wait(K_FETCH, r, lat);
            @(negedge mclk);
            if (lat != 2 + `FIS_TX_REG_LAT) mismatch("done latency", 2 + `FIS_TX_REG_LAT, lat);
            if (rd_cnt - rd0 != 1) mismatch("reg_re count", 1, rd_cnt - rd0);
            if (bad_addr != bad0) begin
                $display("test %s: reg_re came with reg_addr off the command header", cur_name);
                n_err++;
            end
            if (ch_prdtl != r.hdr[31:16]) mismatch("ch_prdtl", 32'(r.hdr[31:16]), 32'(ch_prdtl));
            if (ch_w != r.hdr[6]) mismatch("ch_w", 32'(r.hdr[6]), 32'(ch_w));
            if (ch_cfl != r.hdr[4:0]) mismatch("ch_cfl", 32'(r.hdr[4:0]), 32'(ch_cfl));
        end
        if (r.kind != K_FETCH) begin
            @(negedge mclk);
            first = sink_data.size();
            idx0  = dma_idx;
            issue_and_wait(r.kind, r, lat);
            idx_done = dma_idx;                     // dma_re up to the cycle before done
            drain();
            got = sink_data.size() - first;
            if (r.kind == K_CFIS) begin
                nd = int'(r.hdr[4:0]);
                if (got != r.exp_words) mismatch("word count", r.exp_words, got);
                for (int j = 0; j < got && j < nd; j++) begin
                    exp_d = 32'hC0DE_0000 + 32'(j);  // table pattern at address j
                    if (sink_data[first+j] != exp_d) mismatch($sformatf("word %0d", j),
                        exp_d, sink_data[first+j]);
                    if (sink_type[first+j] != tag_of(j, nd)) mismatch($sformatf("tag %0d", j),
                        32'(tag_of(j, nd)), 32'(sink_type[first+j]));
                end
            end else begin
                nd = (r.xfer > `FIS_TX_MAX_DX_DW) ? `FIS_TX_MAX_DX_DW : r.xfer;
                if (r.err == 0 && got != r.exp_words) mismatch("word count", r.exp_words, got);
                if (r.err != 0 && got > r.exp_words) begin
                    $display("test %s: %0d words after an abort, more than %0d",
                             cur_name, got, r.exp_words);
                    n_err++;
                end
                for (int j = 0; j < got; j++) begin
                    exp_d = (j == 0) ? 32'(`FIS_TX_DATA_FIS) : 32'hD000_0000 + 32'(idx0 + j - 1);
                    if (sink_data[first+j] != exp_d) mismatch($sformatf("word %0d", j),
                        exp_d, sink_data[first+j]);
                    if (sink_type[first+j] != tag_of(j, nd + 1)) mismatch($sformatf("tag %0d", j),
                        32'(tag_of(j, nd + 1)), 32'(sink_type[first+j]));
                end
                exp_sent = (r.err == 0) ? nd : got - 1;
                if (int'(dwords_sent) != exp_sent) mismatch("dwords_sent", exp_sent,
                    32'(dwords_sent));
                if (int'(dx_err) != r.err) mismatch("dx_err", r.err, 32'(dx_err));
                if (dma_idx != idx_done) mismatch("dma_re after done", 0, dma_idx - idx_done);
            end
        end
        if (n_err == err0) begin
            $display("%s: ok", cur_name);
            n_pass++;
        end else begin
            $display("%s: failed", cur_name);
            n_fail++;
        end
    endtask

    initial begin
        for (int i = 0; i < NROWS; i++) begin
            limit += 4 * rows[i].exp_words + 200;   // cycle budget for the whole run
        end
        repeat (2) @(posedge mclk);
        hba_rst <= 1'b0;
        for (int i = 0; i < NROWS; i++) begin
            run_row(i);
        end
        $display("%0d tests passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+rtl
rtl/fis_tx_pkg.sv
rtl/chead_fetch.sv
rtl/cfis_sender.sv
rtl/dx_sender.sv
rtl/todev_stage.sv
rtl/fis_transmit.sv
bench/fis_transmit_tb.sv

// File: Makefile
TOP = fis_transmit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
